// File: Bender.yml
package:
  name: cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/register_file.sv
  - verilog/execute_stage.sv
  - verilog/cpu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpu_tb.sv

// File: verification/cpu_ref_model.svh
// Instruction fields are imm [31:16], spare [15:14], rb [13:11], ra [10:8], rd [7:5] and
// opcode [4:0].
function automatic logic [31:0] encode_instr(input logic [4:0] op, input int rd, input int ra,
                                             input int rb, input int imm);
    return {imm[15:0], 2'b00, rb[2:0], ra[2:0], rd[2:0], op};
endfunction

// ==================================================
// Reference interpreter
// ==================================================

// Runs the program in mem and fills the expected store queues.
// Returns the number of instructions executed, the halt included.
function automatic int run_reference(input int limit);
    logic [31:0] regs [8];
    logic [7:0]  flags;
    logic [31:0] image [mem_words];
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [4:0]  op;
    logic [2:0]  rd;
    logic [2:0]  ra;
    logic [2:0]  rb;
    int          count;
    image = mem;  // Stores may land in program space, so the model keeps its own copy.
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    flags = '0;
    pc    = '0;
    count = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_instr.delete();
    expected_halt = 1'b0;
    while (count < limit) begin
        word  = image[pc[7:0]];
        count = count + 1;
        op    = word[4:0];
        rd    = word[7:5];
        ra    = word[10:8];
        rb    = word[13:11];
        a     = regs[ra];
        b     = regs[rb];
        sext  = {{16{word[31]}}, word[31:16]};
        zext  = {16'h0000, word[31:16]};
        case (op)
            op_add:   regs[rd] = a + b;
            op_sub:   regs[rd] = a - b;
            op_and:   regs[rd] = a & b;
            op_or:    regs[rd] = a | b;
            op_xor:   regs[rd] = a ^ b;
            op_shl:   regs[rd] = a << b[4:0];
            op_shr:   regs[rd] = a >> b[4:0];
            op_ldi:   regs[rd] = sext;
            op_lui:   regs[rd] = {word[31:16], 16'h0000};
            op_addi:  regs[rd] = a + sext;
            op_cmplt: flags[rd] = (a < b);
            op_cmpeq: flags[rd] = (a == b);
            op_st: begin
                exp_addr.push_back(a);
                exp_data.push_back(b);
                exp_instr.push_back(count);
                image[a[7:0]] = b;
            end
            op_halt: begin
                expected_halt    = 1'b1;
                expected_halt_pc = pc;
                return count;
            end
            default: begin
            end
        endcase
        if ((op == op_bf && flags[ra]) || op == op_jmp) begin
            pc = zext;
        end else begin
            pc = pc + 1;
        end
    end
    return count;
endfunction

// File: verification/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int mem_words   = 256;
    localparam int instr_limit = 120;
    localparam int test_count  = 8;
    localparam int halt_watch  = 20;
    localparam int watchdog_ns = (test_count * instr_limit * 4 + test_count * 60) * 8;

    logic        clock;
    logic        rst;
    logic [31:0] data;
    logic [31:0] data_out;
    logic [31:0] address;
    logic        rw;
    logic        halted;

    logic [31:0] mem [mem_words];
    logic [7:0]  read_index;
    int          program_length;
    integer      seed;

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_instr [$];
    logic        expected_halt;
    logic [31:0] expected_halt_pc;

    logic        running;
    logic        reset_applied;
    int          cycle;
    int          halt_cycle;
    logic [31:0] halt_address;
    int          errors;
    int          pass_count;
    int          fail_count;

    `include "cpu_ref_model.svh"

    cpu u_cpu (
        .clock    (clock),
        .rst      (rst),
        .data     (data),
        .data_out (data_out),
        .address  (address),
        .rw       (rw),
        .halted   (halted)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // ==================================================
    // Memory model
    // ==================================================

    always @(negedge clock) begin
        read_index = address[7:0];  // Sampled mid-cycle, where the port is stable.
        if (rw) begin
            mem[address[7:0]] = data_out;
        end
    end

    always @(posedge clock) begin
        reset_applied <= rst;
        #1 data <= mem[read_index];  // The word arrives one cycle after its address.
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_store();
        if (exp_addr.size() == 0) begin
            report_problem($sformatf("Unexpected store of %h to address %h in cycle %0d.",
                                     data_out, address, cycle));
        end else begin
            assert (address == exp_addr[0] && data_out == exp_data[0])
            else report_mismatch($sformatf("store %h to %h, expected %h to %h",
                                           data_out, address, exp_data[0], exp_addr[0]));
            assert (cycle == 4 * exp_instr[0])
            else report_mismatch($sformatf("store in cycle %0d, expected cycle %0d",
                                           cycle, 4 * exp_instr[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_instr.pop_front());
        end
    endtask

    // ==================================================
    // Port checker
    // ==================================================

    always @(negedge clock) begin
        if (reset_applied && rst) begin
            assert (rw == 1'b0 && halted == 1'b0)
            else report_mismatch($sformatf("rw %b halted %b during reset", rw, halted));
        end
        if (running) begin
            cycle++;
            if (cycle == 1) begin
                assert (address == 0 && rw == 1'b0 && halted == 1'b0)
                else report_mismatch($sformatf("first fetch at %h with rw %b", address, rw));
            end
            if (rw) begin
                compare_store();
            end
            if (halted && halt_cycle == 0) begin
                halt_cycle   = cycle;
                halt_address = address;
            end else if (halt_cycle != 0 && cycle <= halt_cycle + halt_watch) begin
                assert (halted && !rw && address == halt_address)
                else report_mismatch($sformatf("port moved after halt, address %h rw %b",
                                               address, rw));
            end
        end
    end

    task automatic clear_memory();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'h5a5a_0000 | i;
        end
        program_length = 0;
    endtask

    task automatic append_instr(input logic [31:0] word);
        mem[program_length] = word;
        program_length++;
    endtask

    // Stores get an address from a preceding op_ldi so they stay above the program.
    task automatic build_random_program();
        int kind;
        int ra;
        clear_memory();
        while (program_length < 30) begin
            kind = $unsigned($random(seed)) % 6;
            case (kind)
                0: append_instr(encode_instr(5'(1 + $unsigned($random(seed)) % 7),
                                             $random(seed), $random(seed), $random(seed), 0));
                1: append_instr(encode_instr(op_ldi, $random(seed), 0, 0, $random(seed)));
                2: append_instr(encode_instr(op_lui, $random(seed), 0, 0, $random(seed)));
                3: append_instr(encode_instr(op_addi, $random(seed), $random(seed), 0,
                                             $random(seed)));
                4: append_instr(encode_instr(($random(seed) & 1) ? op_cmplt : op_cmpeq,
                                             $random(seed), $random(seed), $random(seed), 0));
                default: begin
                    ra = $unsigned($random(seed)) % 8;
                    append_instr(encode_instr(op_ldi, ra, 0, 0, 'h80 | ($random(seed) & 'h7f)));
                    append_instr(encode_instr(op_st, 0, ra, $random(seed), 0));
                end
            endcase
        end
        append_instr(encode_instr(op_halt, 0, 0, 0, 0));
    endtask

    task automatic run_program(input string name);
        int count;
        errors = 0;
        @(posedge clock);
        #1;
        rst     = 1'b1;
        running = 1'b0;
        count   = run_reference(instr_limit);
        repeat (3) @(posedge clock);
        #1;
        cycle      = 0;
        halt_cycle = 0;
        rst        = 1'b0;
        running    = 1'b1;
        while (!(halt_cycle != 0 && cycle >= halt_cycle + halt_watch) &&
               cycle < 4 * instr_limit + 8) begin
            @(posedge clock);
        end
        running = 1'b0;
        if (!expected_halt) begin
            report_problem("The reference model ran out of instructions before a halt.");
        end
        if (halt_cycle == 0) begin
            report_problem("The DUT never raised halted.");
        end else begin
            assert (halt_cycle == 4 * count + 1)
            else report_mismatch($sformatf("halted seen in cycle %0d, expected %0d",
                                           halt_cycle, 4 * count + 1));
            assert (halt_address == expected_halt_pc + 1)
            else report_mismatch($sformatf("address %h after halt", halt_address));
        end
        if (exp_addr.size() != 0) begin
            report_problem($sformatf("%0d expected stores never appeared.", exp_addr.size()));
        end
        if (errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %s: %s, %0d instructions", name, (errors == 0) ? "pass" : "FAIL", count);
    endtask

    initial begin
        #(watchdog_ns * 1ns);
        $display("Watchdog expired before the tests finished.");
        $display("Checks failed");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        opcode_t alu_ops [7];
        alu_ops    = '{op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
        rst        = 1'b1;
        data       = '0;
        running    = 1'b0;
        seed       = 32'h7e58;
        cycle      = 0;
        halt_cycle = 0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;

        clear_memory();
        append_instr(encode_instr(op_ldi, 1, 0, 0, 5));
        append_instr(encode_instr(op_ldi, 2, 0, 0, 7));
        append_instr(encode_instr(op_add, 3, 1, 2, 0));
        append_instr(encode_instr(op_ldi, 4, 0, 0, 'h90));
        append_instr(encode_instr(op_st, 0, 4, 3, 0));
        append_instr(encode_instr(op_halt, 0, 0, 0, 0));
        run_program("straight_line");

        clear_memory();
        append_instr(encode_instr(op_ldi, 1, 0, 0, 'hf0f0));  // Sign-extends to ffff_f0f0.
        append_instr(encode_instr(op_lui, 2, 0, 0, 'h1234));
        append_instr(encode_instr(op_addi, 2, 2, 0, 'h5678));
        append_instr(encode_instr(op_ldi, 7, 0, 0, 'ha0));
        for (int i = 0; i < 7; i++) begin
            append_instr(encode_instr(alu_ops[i], 4, 1, 2, 0));
            append_instr(encode_instr(op_st, 0, 7, 4, 0));
            append_instr(encode_instr(op_addi, 7, 7, 0, 1));
        end
        append_instr(encode_instr(op_addi, 5, 1, 0, -3));
        append_instr(encode_instr(op_st, 0, 7, 5, 0));
        // The compare is unsigned, so ffff_f0f0 is not below 1234_5678 and the store runs.
        append_instr(encode_instr(op_cmplt, 3, 1, 2, 0));
        append_instr(encode_instr(op_bf, 0, 3, 0, program_length + 2));
        append_instr(encode_instr(op_st, 0, 7, 1, 0));
        append_instr(encode_instr(op_cmpeq, 3, 1, 1, 0));
        append_instr(encode_instr(op_bf, 0, 3, 0, program_length + 2));  // Skips the store.
        append_instr(encode_instr(op_st, 0, 7, 2, 0));
        append_instr(encode_instr(op_halt, 0, 0, 0, 0));
        run_program("alu");

        // The loop body starts at word 3, and the exit jump at word 8 skips words 9 and 10.
        clear_memory();
        append_instr(encode_instr(op_ldi, 1, 0, 0, 0));
        append_instr(encode_instr(op_ldi, 2, 0, 0, 5));
        append_instr(encode_instr(op_ldi, 6, 0, 0, 'hc0));
        append_instr(encode_instr(op_addi, 1, 1, 0, 1));
        append_instr(encode_instr(op_st, 0, 6, 1, 0));
        append_instr(encode_instr(op_addi, 6, 6, 0, 1));
        append_instr(encode_instr(op_cmplt, 3, 1, 2, 0));
        append_instr(encode_instr(op_bf, 0, 3, 0, 3));
        append_instr(encode_instr(op_jmp, 0, 0, 0, 11));
        append_instr(encode_instr(op_ldi, 4, 0, 0, 'hdead));
        append_instr(encode_instr(op_st, 0, 6, 4, 0));
        append_instr(encode_instr(op_ldi, 4, 0, 0, 'h77));
        append_instr(encode_instr(op_st, 0, 6, 4, 0));
        append_instr(encode_instr(op_halt, 0, 0, 0, 0));
        run_program("branch");

        clear_memory();
        append_instr(encode_instr(op_nop, 0, 0, 0, 0));
        append_instr(encode_instr(5'd31, 1, 2, 3, 'hffff));  // Unknown code acts as op_nop.
        append_instr(encode_instr(op_ldi, 4, 0, 0, 'h90));
        append_instr(encode_instr(op_st, 0, 4, 1, 0));  // Register 1 is still zero here.
        append_instr(encode_instr(op_halt, 0, 0, 0, 0));
        run_program("halt");

        for (int p = 0; p < 4; p++) begin
            build_random_program();
            run_program($sformatf("random_%0d", p));
        end

        $display("Tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/cpu.sv
verification/cpu_tb.sv

// File: verilog/cpu.sv
module cpu (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [cpu_pkg::word_width-1:0]  data,
    output logic [cpu_pkg::word_width-1:0]  data_out,
    output logic [cpu_pkg::word_width-1:0]  address,
    output logic                            rw,
    output logic                            halted
);
    import cpu_pkg::*;

    phase_t                     phase;
    decoded_t                   decoded;
    result_t                    result;
    logic [reg_index_width-1:0] read_a;
    logic [reg_index_width-1:0] read_b;
    logic [word_width-1:0]      a_value;
    logic [word_width-1:0]      b_value;
    logic                       a_flag;

    // Sequencer and sole driver of the memory port.
    fetch_stage u_fetch (
        .clock    (clock),
        .rst      (rst),
        .result   (result),
        .phase    (phase),
        .address  (address),
        .data_out (data_out),
        .rw       (rw),
        .halted   (halted)
    );

    decode_stage u_decode (
        .clock     (clock),
        .rst       (rst),
        .phase     (phase),
        .data      (data),
        .read_a    (read_a),
        .read_b    (read_b),
        .a_value   (a_value),
        .b_value   (b_value),
        .a_flag_in (a_flag),
        .decoded   (decoded)
    );

    register_file u_regs (
        .clock   (clock),
        .rst     (rst),
        .phase   (phase),
        .read_a  (read_a),
        .read_b  (read_b),
        .a_value (a_value),
        .b_value (b_value),
        .a_flag  (a_flag),
        .result  (result)
    );

    execute_stage u_execute (
        .clock   (clock),
        .rst     (rst),
        .phase   (phase),
        .decoded (decoded),
        .result  (result)
    );

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // ==================================================
    // Widths
    // ==================================================

    localparam int word_width = 32;
    localparam int reg_count = 8;
    localparam int reg_index_width = 3;
    localparam int imm_width = 16;
    localparam int opcode_width = 5;

    // ==================================================
    // Opcodes and phases
    // ==================================================

    // Codes above op_halt are treated as op_nop by the decoder.
    typedef enum logic [opcode_width-1:0] {
        op_nop   = 5'd0,
        op_add   = 5'd1,
        op_sub   = 5'd2,
        op_and   = 5'd3,
        op_or    = 5'd4,
        op_xor   = 5'd5,
        op_shl   = 5'd6,
        op_shr   = 5'd7,
        op_ldi   = 5'd8,
        op_lui   = 5'd9,
        op_addi  = 5'd10,
        op_cmplt = 5'd11,
        op_cmpeq = 5'd12,
        op_bf    = 5'd13,
        op_jmp   = 5'd14,
        op_st    = 5'd15,
        op_halt  = 5'd16
    } opcode_t;

    typedef enum logic [1:0] {
        phase_fetch     = 2'd0,
        phase_decode    = 2'd1,
        phase_execute   = 2'd2,
        phase_writeback = 2'd3
    } phase_t;

    // ==================================================
    // Structures
    // ==================================================

    // Raw instruction word. The opcode stays raw here so that unknown codes survive.
    typedef struct packed {
        logic [imm_width-1:0]       imm;
        logic [1:0]                 spare;
        logic [reg_index_width-1:0] rb;
        logic [reg_index_width-1:0] ra;
        logic [reg_index_width-1:0] rd;
        logic [opcode_width-1:0]    opcode;
    } instr_t;

    typedef struct packed {
        opcode_t                    opcode;
        logic [reg_index_width-1:0] rd;
        logic [word_width-1:0]      imm;     // Already widened.
        logic [word_width-1:0]      a_value;
        logic [word_width-1:0]      b_value;
        logic                       a_flag;  // Flag of register ra.
    } decoded_t;

    typedef struct packed {
        logic                       reg_write;
        logic [reg_index_width-1:0] rd;
        logic [word_width-1:0]      reg_value;
        logic                       flag_write;
        logic                       flag_value;
        logic                       store;
        logic [word_width-1:0]      store_address;
        logic [word_width-1:0]      store_data;
        logic                       branch_taken;
        logic [word_width-1:0]      branch_target;
        logic                       halt;
    } result_t;

endpackage

// File: verilog/decode_stage.sv
module decode_stage (
    input  logic                                 clock,
    input  logic                                 rst,
    input  cpu_pkg::phase_t                      phase,
    input  logic [cpu_pkg::word_width-1:0]       data,
    output logic [cpu_pkg::reg_index_width-1:0]  read_a,
    output logic [cpu_pkg::reg_index_width-1:0]  read_b,
    input  logic [cpu_pkg::word_width-1:0]       a_value,
    input  logic [cpu_pkg::word_width-1:0]       b_value,
    input  logic                                 a_flag_in,
    output cpu_pkg::decoded_t                    decoded
);
    import cpu_pkg::*;

    instr_t                instr;
    opcode_t               opcode;
    logic [word_width-1:0] imm_sext;
    logic [word_width-1:0] imm_zext;
    logic [word_width-1:0] imm_wide;

    // Memory answers the fetch during phase_decode, so the word is used as it arrives.
    assign instr = instr_t'(data);

    assign read_a = instr.ra;
    assign read_b = instr.rb;

    assign imm_sext = {{(word_width-imm_width){instr.imm[imm_width-1]}}, instr.imm};
    assign imm_zext = {{(word_width-imm_width){1'b0}}, instr.imm};

    // ==================================================
    // Opcode check and immediate widening
    // ==================================================

    always_comb begin
        if (instr.opcode <= op_halt) begin
            opcode = opcode_t'(instr.opcode);
        end else begin
            opcode = op_nop;  // Unknown codes do nothing.
        end
    end

    always_comb begin
        case (opcode)
            op_ldi, op_addi: imm_wide = imm_sext;
            default:         imm_wide = imm_zext;  // op_lui, op_bf and op_jmp.
        endcase
    end

    // ==================================================
    // Decode register
    // ==================================================

    always_ff @(posedge clock) begin
        if (rst) begin
            decoded <= '0;
        end else if (phase == phase_decode) begin
            decoded.opcode  <= opcode;
            decoded.rd      <= instr.rd;
            decoded.imm     <= imm_wide;
            decoded.a_value <= a_value;
            decoded.b_value <= b_value;
            decoded.a_flag  <= a_flag_in;
        end
    end

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
    input  logic              clock,
    input  logic              rst,
    input  cpu_pkg::phase_t   phase,
    input  cpu_pkg::decoded_t decoded,
    output cpu_pkg::result_t  result
);
    import cpu_pkg::*;

    result_t               result_next;
    logic [word_width-1:0] a;
    logic [word_width-1:0] b;
    logic [4:0]            shift_amount;

    assign a = decoded.a_value;
    assign b = decoded.b_value;
    assign shift_amount = b[4:0];

    // ==================================================
    // ALU, compares and branch resolution
    // ==================================================

    always_comb begin
        result_next    = '0;
        result_next.rd = decoded.rd;
        case (decoded.opcode)
            op_add: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a + b;
            end
            op_sub: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a - b;
            end
            op_and: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a & b;
            end
            op_or: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a | b;
            end
            op_xor: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a ^ b;
            end
            op_shl: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a << shift_amount;
            end
            op_shr: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a >> shift_amount;  // Logical shift.
            end
            op_ldi: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = decoded.imm;
            end
            op_lui: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = {decoded.imm[imm_width-1:0],
                                         {(word_width-imm_width){1'b0}}};
            end
            op_addi: begin
                result_next.reg_write = 1'b1;
                result_next.reg_value = a + decoded.imm;
            end
            op_cmplt: begin
                result_next.flag_write = 1'b1;
                result_next.flag_value = (a < b);  // Unsigned.
            end
            op_cmpeq: begin
                result_next.flag_write = 1'b1;
                result_next.flag_value = (a == b);
            end
            op_bf: begin
                result_next.branch_taken  = decoded.a_flag;
                result_next.branch_target = decoded.imm;
            end
            op_jmp: begin
                result_next.branch_taken  = 1'b1;
                result_next.branch_target = decoded.imm;
            end
            op_st: begin
                // Register ra holds the address and rb the data.
                result_next.store         = 1'b1;
                result_next.store_address = a;
                result_next.store_data    = b;
            end
            op_halt: begin
                result_next.halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            result <= '0;
        end else if (phase == phase_execute) begin
            result <= result_next;
        end
    end

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage (
    input  logic                            clock,
    input  logic                            rst,
    input  cpu_pkg::result_t                result,
    output cpu_pkg::phase_t                 phase,
    output logic [cpu_pkg::word_width-1:0]  address,
    output logic [cpu_pkg::word_width-1:0]  data_out,
    output logic                            rw,
    output logic                            halted
);
    import cpu_pkg::*;

    logic [word_width-1:0] pc;
    logic                  store_cycle;
    logic [word_width-1:0] pc_next;

    // ==================================================
    // Memory port
    // ==================================================

    // The port belongs to the store only in write-back of an op_st.
    assign store_cycle = (phase == phase_writeback) && result.store;

    assign rw       = store_cycle;
    assign address  = store_cycle ? result.store_address : pc;
    assign data_out = result.store_data;  // Only sampled by memory while rw is high.

    assign pc_next = result.branch_taken ? result.branch_target : pc + 1'b1;

    // ==================================================
    // Phase sequencer and program counter
    // ==================================================

    always_ff @(posedge clock) begin
        if (rst) begin
            phase  <= phase_fetch;
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            case (phase)
                phase_fetch: begin
                    phase <= phase_decode;
                end
                phase_decode: begin
                    phase <= phase_execute;
                end
                phase_execute: begin
                    phase <= phase_writeback;
                end
                phase_writeback: begin
                    phase  <= phase_fetch;
                    pc     <= pc_next;
                    halted <= result.halt;  // Freezes the sequencer at phase_fetch.
                end
                default: begin
                    phase <= phase_fetch;
                end
            endcase
        end
    end

endmodule

// File: verilog/register_file.sv
module register_file (
    input  logic                                 clock,
    input  logic                                 rst,
    input  cpu_pkg::phase_t                      phase,
    input  logic [cpu_pkg::reg_index_width-1:0]  read_a,
    input  logic [cpu_pkg::reg_index_width-1:0]  read_b,
    output logic [cpu_pkg::word_width-1:0]       a_value,
    output logic [cpu_pkg::word_width-1:0]       b_value,
    output logic                                 a_flag,
    input  cpu_pkg::result_t                     result
);
    import cpu_pkg::*;

    logic [word_width-1:0] regs [reg_count];
    logic [reg_count-1:0]  flags;
    logic                  wb_cycle;

    // Reads are combinational so decode sees the previous write-back.
    assign a_value = regs[read_a];
    assign b_value = regs[read_b];
    assign a_flag  = flags[read_a];

    assign wb_cycle = (phase == phase_writeback);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else if (wb_cycle) begin
            if (result.reg_write) begin
                regs[result.rd] <= result.reg_value;
            end
            if (result.flag_write) begin
                flags[result.rd] <= result.flag_value;  // Flag index is rd as well.
            end
        end
    end

endmodule
